// ==== verilog/dmaCtrlPkg.sv ====
`default_nettype none

package dmaCtrlPkg;

  localparam int NUM_CHANNELS = 4;

  typedef logic [15:0] dmaCtrl_t;

  // control word bit positions
  localparam int CTRL_ENABLE   = 15;
  localparam int CTRL_IRQ      = 14;
  localparam int CTRL_WORD     = 10;  // set for word units, clear for halfword
  localparam int CTRL_REPEAT   = 9;
  localparam int CTRL_SRC_STEP = 7;   // lsb of 2-bit field, bits 8..7
  localparam int CTRL_DST_STEP = 5;   // lsb of 2-bit field, bits 6..5

  // reload only applies to the destination
  typedef enum logic [1:0] {
    STEP_INC        = 2'b00,
    STEP_DEC        = 2'b01,
    STEP_FIXED      = 2'b10,
    STEP_INC_RELOAD = 2'b11
  } stepMode_t;

  typedef logic [13:0] unitCount_t;  // zero means 16384 units

  typedef enum logic [2:0] {
    OFF,
    IDLE,
    QUEUED,
    READ,
    WRITE,
    PREEMPTED
  } chanState_t;

endpackage

`default_nettype wire

// ==== verilog/dmaBusPkg.sv ====
`default_nettype none

package dmaBusPkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [1:0]        busSize_t;

  localparam busSize_t SIZE_HALF = 2'b01;
  localparam busSize_t SIZE_WORD = 2'b10;

  // address step per unit, in bytes
  localparam int STEP_HALF = 2;
  localparam int STEP_WORD = 4;

endpackage

`default_nettype wire

// ==== verilog/dmaBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dmaBusIf;
  import dmaBusPkg::*;

  logic     active;     // channel in READ or WRITE
  logic     wantsBus;
  addr_t    addr;
  data_t    wdata;
  busSize_t size;
  logic     wen;
  logic     preempted;  // a higher priority channel claims the bus
  logic     busFree;
  data_t    rdata;
  logic     memWait;

  modport chan (
    output active, wantsBus, addr, wdata, size, wen,
    input  preempted, busFree, rdata, memWait
  );

  modport arb (
    input  active, wantsBus, addr, wdata, size, wen,
    output preempted, busFree, rdata, memWait
  );

endinterface

`default_nettype wire

// ==== verilog/dmaChannelFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaChannelFsm (
  input  logic                   clk,
  input  logic                   rst_b,
  input  dmaCtrlPkg::dmaCtrl_t   ctrl,
  input  logic                   start,
  input  logic                   lastUnit,
  dmaBusIf.chan                  bus,
  output logic                   loadRegs,
  output logic                   stepSrc,
  output logic                   stepDst,
  output logic                   captureData,
  output logic                   reloadCount,
  output logic                   irq,
  output logic                   disableDma,
  output dmaCtrlPkg::chanState_t state
);
  import dmaCtrlPkg::*;

  chanState_t nextState;
  logic       enablePrev;
  logic       canStart;
  logic       irqNext;
  logic       disableNext;

  assign canStart = bus.busFree && !bus.preempted;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state      <= OFF;
      enablePrev <= 1'b0;
      irq        <= 1'b0;
      disableDma <= 1'b0;
    end else begin
      state      <= nextState;
      enablePrev <= ctrl[CTRL_ENABLE];
      irq        <= irqNext;     // one cycle, state has left WRITE
      disableDma <= disableNext;
    end
  end

  always_comb begin
    nextState   = state;
    loadRegs    = 1'b0;
    stepSrc     = 1'b0;
    stepDst     = 1'b0;
    captureData = 1'b0;
    reloadCount = 1'b0;
    irqNext     = 1'b0;
    disableNext = 1'b0;
    case (state)
      OFF: begin
        if (ctrl[CTRL_ENABLE] && !enablePrev) begin  // enable edge
          loadRegs  = 1'b1;
          nextState = IDLE;
        end
      end
      IDLE: begin
        if (!ctrl[CTRL_ENABLE]) begin
          nextState = OFF;
        end else if (start) begin
          nextState = canStart ? READ : QUEUED;
        end
      end
      QUEUED: begin
        if (start && canStart) begin
          nextState = READ;
        end
      end
      READ: begin
        if (!bus.memWait) begin
          captureData = 1'b1;
          stepSrc     = 1'b1;
          nextState   = WRITE;
        end
      end
      WRITE: begin
        if (!bus.memWait) begin
          stepDst = 1'b1;
          if (lastUnit) begin
            reloadCount = 1'b1;
            irqNext     = ctrl[CTRL_IRQ];
            if (ctrl[CTRL_REPEAT]) begin
              nextState = IDLE;
            end else begin
              disableNext = 1'b1;
              nextState   = OFF;
            end
          end else begin
            // yield only between units
            nextState = bus.preempted ? PREEMPTED : READ;
          end
        end
      end
      PREEMPTED: begin
        if (canStart) begin
          nextState = READ;
        end
      end
      default: nextState = OFF;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/dmaAddrPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaAddrPath (
  input  logic                   clk,
  input  logic                   rst_b,
  input  dmaCtrlPkg::dmaCtrl_t   ctrl,
  input  dmaBusPkg::addr_t       srcIn,
  input  dmaBusPkg::addr_t       dstIn,
  input  dmaCtrlPkg::unitCount_t countIn,
  input  dmaBusPkg::data_t       rdata,
  input  logic                   loadRegs,
  input  logic                   stepSrc,
  input  logic                   stepDst,
  input  logic                   captureData,
  input  logic                   reloadCount,
  input  dmaCtrlPkg::chanState_t state,
  output dmaBusPkg::addr_t       addr,
  output dmaBusPkg::data_t       wdata,
  output dmaBusPkg::busSize_t    size,
  output logic                   lastUnit
);
  import dmaCtrlPkg::*;
  import dmaBusPkg::*;

  addr_t      srcReg;
  addr_t      dstReg;
  addr_t      stepAmt;
  data_t      dataReg;
  unitCount_t countReg;
  unitCount_t doneCount;
  unitCount_t nextDone;
  stepMode_t  srcMode;
  stepMode_t  dstMode;
  logic       dstReload;

  function automatic addr_t nextAddr(addr_t a, stepMode_t mode, addr_t amt);
    case (mode)
      STEP_DEC:   return a - amt;
      STEP_FIXED: return a;
      default:    return a + amt;  // source treats reload as increment
    endcase
  endfunction

  assign srcMode   = stepMode_t'(ctrl[CTRL_SRC_STEP +: 2]);
  assign dstMode   = stepMode_t'(ctrl[CTRL_DST_STEP +: 2]);
  assign stepAmt   = ctrl[CTRL_WORD] ? addr_t'(STEP_WORD) : addr_t'(STEP_HALF);
  assign dstReload = reloadCount && ctrl[CTRL_REPEAT] && (dstMode == STEP_INC_RELOAD);

  always_ff @(posedge clk) begin
    if (loadRegs) begin
      srcReg   <= srcIn;
      dstReg   <= dstIn;
      countReg <= countIn;
    end else begin
      if (stepSrc) srcReg <= nextAddr(srcReg, srcMode, stepAmt);
      if (stepDst) dstReg <= dstReload ? dstIn : nextAddr(dstReg, dstMode, stepAmt);
    end
    if (captureData) dataReg <= rdata;
  end

  // 14-bit wrap makes a count of zero mean 16384
  assign nextDone = doneCount + 1'b1;
  assign lastUnit = (nextDone == countReg);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) doneCount <= '0;
    else if (loadRegs || reloadCount) doneCount <= '0;
    else if (stepDst) doneCount <= nextDone;
  end

  assign addr = (state == WRITE) ? dstReg : srcReg;
  assign size = ctrl[CTRL_WORD] ? SIZE_WORD : SIZE_HALF;

  always_comb begin
    wdata = dataReg;
    if (!ctrl[CTRL_WORD] && dstReg[1]) wdata[31:16] = dataReg[15:0];  // upper lane
  end

endmodule

`default_nettype wire

// ==== verilog/dmaChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaChannel (
  input  logic                   clk,
  input  logic                   rst_b,
  input  dmaCtrlPkg::dmaCtrl_t   ctrl,
  input  dmaBusPkg::addr_t       srcAddr,
  input  dmaBusPkg::addr_t       dstAddr,
  input  dmaCtrlPkg::unitCount_t unitCount,
  input  logic                   start,
  dmaBusIf.chan                  bus,
  output logic                   irq,
  output logic                   disableDma
);
  import dmaCtrlPkg::*;

  chanState_t state;
  logic       loadRegs;
  logic       stepSrc;
  logic       stepDst;
  logic       captureData;
  logic       reloadCount;
  logic       lastUnit;

  assign bus.active   = (state == READ) || (state == WRITE);
  assign bus.wen      = (state == WRITE);
  assign bus.wantsBus = ((state == IDLE) && start) || (state == QUEUED) ||
                        (state == PREEMPTED);

  dmaChannelFsm fsm (
    .clk,
    .rst_b,
    .ctrl,
    .start,
    .lastUnit,
    .bus,
    .loadRegs,
    .stepSrc,
    .stepDst,
    .captureData,
    .reloadCount,
    .irq,
    .disableDma,
    .state
  );

  dmaAddrPath path (
    .clk,
    .rst_b,
    .ctrl,
    .srcIn(srcAddr),
    .dstIn(dstAddr),
    .countIn(unitCount),
    .rdata(bus.rdata),
    .loadRegs,
    .stepSrc,
    .stepDst,
    .captureData,
    .reloadCount,
    .state,
    .addr(bus.addr),
    .wdata(bus.wdata),
    .size(bus.size),
    .lastUnit
  );

endmodule

`default_nettype wire

// ==== verilog/dmaArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaArbiter (
  dmaBusIf.arb                chan [dmaCtrlPkg::NUM_CHANNELS],
  input  dmaBusPkg::data_t    rdata,
  input  logic                memWait,
  output dmaBusPkg::addr_t    addr,
  output dmaBusPkg::data_t    wdata,
  output dmaBusPkg::busSize_t size,
  output logic                wen,
  output logic                busActive
);
  import dmaCtrlPkg::*;
  import dmaBusPkg::*;

  logic [NUM_CHANNELS-1:0] activeVec;
  logic [NUM_CHANNELS-1:0] claimVec;
  logic [NUM_CHANNELS-1:0] preemptVec;
  logic [NUM_CHANNELS-1:0] wenVec;
  addr_t                   addrArr [NUM_CHANNELS];
  data_t                   wdataArr [NUM_CHANNELS];
  busSize_t                sizeArr [NUM_CHANNELS];

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gChan
    assign activeVec[i] = chan[i].active;
    assign claimVec[i]  = chan[i].active | chan[i].wantsBus;
    assign wenVec[i]    = chan[i].wen;
    assign addrArr[i]   = chan[i].addr;
    assign wdataArr[i]  = chan[i].wdata;
    assign sizeArr[i]   = chan[i].size;

    assign chan[i].preempted = preemptVec[i];
    assign chan[i].busFree   = !busActive;
    assign chan[i].rdata     = rdata;
    assign chan[i].memWait   = memWait;
  end

  // channel 0 is never preempted, each lower index outranks the rest
  always_comb begin
    preemptVec[0] = 1'b0;
    for (int i = 1; i < NUM_CHANNELS; i++) begin
      preemptVec[i] = preemptVec[i-1] | claimVec[i-1];
    end
  end

  assign busActive = |activeVec;

  always_comb begin
    addr  = '0;
    wdata = '0;
    size  = '0;
    wen   = 1'b0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      if (activeVec[i]) begin  // at most one is active
        addr  = addrArr[i];
        wdata = wdataArr[i];
        size  = sizeArr[i];
        wen   = wenVec[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dmaController.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaController (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  dmaCtrlPkg::dmaCtrl_t                 ctrl [dmaCtrlPkg::NUM_CHANNELS],
  input  dmaBusPkg::addr_t                     srcAddr [dmaCtrlPkg::NUM_CHANNELS],
  input  dmaBusPkg::addr_t                     dstAddr [dmaCtrlPkg::NUM_CHANNELS],
  input  dmaCtrlPkg::unitCount_t               unitCount [dmaCtrlPkg::NUM_CHANNELS],
  input  logic [dmaCtrlPkg::NUM_CHANNELS-1:0]  startReq,
  input  logic                                 memWait,
  input  dmaBusPkg::data_t                     rdata,
  output dmaBusPkg::addr_t                     addr,
  output dmaBusPkg::data_t                     wdata,
  output dmaBusPkg::busSize_t                  size,
  output logic                                 wen,
  output logic                                 busActive,
  output logic [dmaCtrlPkg::NUM_CHANNELS-1:0]  irq,
  output logic [dmaCtrlPkg::NUM_CHANNELS-1:0]  disableDma
);
  import dmaCtrlPkg::*;

  dmaBusIf busIf [NUM_CHANNELS] ();  // one link per channel

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gChan
    dmaChannel chan (
      .clk,
      .rst_b,
      .ctrl(ctrl[i]),
      .srcAddr(srcAddr[i]),
      .dstAddr(dstAddr[i]),
      .unitCount(unitCount[i]),
      .start(startReq[i]),
      .bus(busIf[i]),
      .irq(irq[i]),
      .disableDma(disableDma[i])
    );
  end

  dmaArbiter arb (
    .chan(busIf),
    .rdata,
    .memWait,
    .addr,
    .wdata,
    .size,
    .wen,
    .busActive
  );

endmodule

`default_nettype wire

// ==== test/dmaChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaChecker (
  input logic        clk,
  input logic        rst_b,
  input logic [3:0]  startReq,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input logic [1:0]  size,
  input logic        wen,
  input logic        busActive,
  input logic        memWait,
  input logic [3:0]  irq,
  input logic [3:0]  disableDma
);
  int          errors = 0;
  int          checks = 0;
  logic [15:0] chCtrl [4];
  logic [31:0] chSrc [4];
  logic [31:0] chDst [4];
  int          chCount [4];
  int          seen [4];
  int          irqSeen [4];
  int          offSeen [4];
  int          lateWrites [4];  // lower priority writes while this channel waits

  initial begin
    for (int i = 0; i < 4; i++) begin
      chCtrl[i]     = 16'h0;
      chSrc[i]      = 32'h0;
      chDst[i]      = 32'h0;
      chCount[i]    = 0;
      seen[i]       = 0;
      irqSeen[i]    = 0;
      offSeen[i]    = 0;
      lateWrites[i] = 0;
    end
  end

  function automatic int totalUnits(int ch);
    return chCtrl[ch][9] ? 2 * chCount[ch] : chCount[ch];  // repeat runs twice
  endfunction

  function automatic int unitsDone(int ch);
    return seen[ch];
  endfunction

  function automatic int unitsLeft();
    int sum;
    sum = 0;
    for (int i = 0; i < 4; i++) sum += totalUnits(i) - seen[i];
    return sum;
  endfunction

  // signed byte step per unit: 01 dec, 10 fixed, others inc
  function automatic int delta(logic [1:0] mode, logic word);
    int b;
    b = word ? 4 : 2;
    if (mode == 2'b01) return -b;
    else if (mode == 2'b10) return 0;
    else return b;
  endfunction

  function automatic logic [31:0] expSrc(int ch, int n);
    return chSrc[ch] + 32'(delta(chCtrl[ch][8:7], chCtrl[ch][10]) * n);
  endfunction

  function automatic logic [31:0] expDst(int ch, int n);
    int idx;
    idx = (chCtrl[ch][6:5] == 2'b11) ? n % chCount[ch] : n;  // reload restarts each pass
    return chDst[ch] + 32'(delta(chCtrl[ch][6:5], chCtrl[ch][10]) * idx);
  endfunction

  function automatic logic [31:0] expData(int ch, int n);
    logic [31:0] m;
    logic [31:0] d;
    m = expSrc(ch, n) ^ 32'hA5A5_0000;
    d = expDst(ch, n);
    if (!chCtrl[ch][10] && d[1]) return {m[15:0], m[15:0]};
    return m;
  endfunction

  task automatic checkCounts(int ch);
    int irqExp;
    int offExp;
    irqExp = chCtrl[ch][14] ? totalUnits(ch) / chCount[ch] : 0;
    offExp = chCtrl[ch][9] ? 0 : 1;
    checks += 3;
    if (seen[ch] != totalUnits(ch)) begin
      errors++;
      $display("channel %0d wrote %0d of %0d units", ch, seen[ch], totalUnits(ch));
    end
    if (irqSeen[ch] != irqExp) begin
      errors++;
      $display("[ERROR] irq[%0d] pulses: got %h, expected %h", ch, irqSeen[ch], irqExp);
    end
    if (offSeen[ch] != offExp) begin
      errors++;
      $display("[ERROR] disableDma[%0d] pulses: got %h, expected %h", ch, offSeen[ch], offExp);
    end
  endtask

  task automatic arm(int ch, logic [15:0] c, logic [31:0] s, logic [31:0] d, logic [13:0] n);
    if (chCount[ch] != 0) checkCounts(ch);  // close out the previous transfer
    chCtrl[ch]     = c;
    chSrc[ch]      = s;
    chDst[ch]      = d;
    chCount[ch]    = (n == 14'h0) ? 16384 : int'(n);
    seen[ch]       = 0;
    irqSeen[ch]    = 0;
    offSeen[ch]    = 0;
    lateWrites[ch] = 0;
  endtask

  task automatic finalCheck();
    for (int i = 0; i < 4; i++) begin
      if (chCount[i] != 0) checkCounts(i);
    end
  endtask

  always @(posedge clk) begin : monitor
    int hit;
    if (rst_b) begin
      checks++;
      if (wen && !busActive) begin
        errors++;
        $display("[ERROR] busActive: got %h, expected %h", busActive, 1'b1);
      end else if (busActive && unitsLeft() == 0) begin
        errors++;
        $display("[ERROR] busActive: got %h, expected %h", busActive, 1'b0);
      end
    end
    if (rst_b && wen && !memWait) begin
      hit = -1;
      for (int i = 0; i < 4; i++) begin
        if (hit < 0 && seen[i] < totalUnits(i) && addr == expDst(i, seen[i])) hit = i;
      end
      checks++;
      if (hit < 0) begin
        errors++;
        $display("unexpected write to %h that matches no pending unit", addr);
      end else begin
        for (int i = 0; i < hit; i++) begin
          if (seen[i] > 0 && seen[i] < totalUnits(i)) begin
            errors++;
            $display("channel %0d wrote while channel %0d was mid-transfer", hit, i);
          end else if (startReq[i] && seen[i] < totalUnits(i)) begin
            lateWrites[i]++;  // one unit may finish before the yield
            if (lateWrites[i] > 1) begin
              errors++;
              $display("channel %0d kept the bus while channel %0d waited", hit, i);
            end
          end
        end
        if (wdata !== expData(hit, seen[hit])) begin
          errors++;
          $display("[ERROR] wdata: got %h, expected %h", wdata, expData(hit, seen[hit]));
        end
        if (size !== (chCtrl[hit][10] ? 2'b10 : 2'b01)) begin
          errors++;
          $display("[ERROR] size: got %h, expected %h", size, chCtrl[hit][10] ? 2'b10 : 2'b01);
        end
        seen[hit]++;
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (rst_b && irq[i]) begin
        irqSeen[i]++;
        if (chCount[i] == 0 || !chCtrl[i][14] || irqSeen[i] > seen[i] / chCount[i]) begin
          errors++;
          $display("irq of channel %0d pulsed outside the end of a transfer", i);
        end
      end
      if (rst_b && disableDma[i]) begin
        offSeen[i]++;
        if (chCount[i] == 0 || chCtrl[i][9] || seen[i] != totalUnits(i)) begin
          errors++;
          $display("disableDma of channel %0d pulsed before its transfer ended", i);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/dmaBus_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaBusProperties (
  input logic        clk,
  input logic        rst_b,
  input logic        memWait,
  input logic        busActive,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input logic [1:0]  size,
  input logic        wen,
  input logic [3:0]  irq,
  input logic [3:0]  disableDma
);

  // a wait state freezes the bus
  holdOnWait: assert property (@(posedge clk) disable iff (!rst_b)
    (busActive && memWait) |=> ($stable(addr) && $stable(wdata) && $stable(size) && $stable(wen)))
    else $error("bus outputs changed during a wait state");

  irqPulse: assert property (@(posedge clk) disable iff (!rst_b)
    (irq & $past(irq)) == 4'b0)
    else $error("irq held high for two cycles");

  offPulse: assert property (@(posedge clk) disable iff (!rst_b)
    (disableDma & $past(disableDma)) == 4'b0)
    else $error("disableDma held high for two cycles");

endmodule

bind dmaController dmaBusProperties props0 (
  .clk(clk), .rst_b(rst_b), .memWait(memWait), .busActive(busActive), .addr(addr),
  .wdata(wdata), .size(size), .wen(wen), .irq(irq), .disableDma(disableDma)
);

`default_nettype wire

// ==== test/dmaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTb;
  localparam int MAX_LINES = 16;

  logic        clk;
  logic        rst_b;
  logic [15:0] ctrl [4];
  logic [31:0] srcAddr [4];
  logic [31:0] dstAddr [4];
  logic [13:0] unitCount [4];
  logic [3:0]  startReq;
  logic        memWait;
  logic [31:0] rdata;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [1:0]  size;
  logic        wen;
  logic        busActive;
  logic [3:0]  irq;
  logic [3:0]  disableDma;

  int          seed;
  int          nLines = 0;
  logic [3:0]  armed;
  int          lineChan [MAX_LINES];
  logic [15:0] lineCtrl [MAX_LINES];
  logic [31:0] lineSrc [MAX_LINES];
  logic [31:0] lineDst [MAX_LINES];
  logic [13:0] lineCount [MAX_LINES];
  logic [3:0]  lineMask [MAX_LINES];

  dmaController dut0 (
    .clk, .rst_b, .ctrl, .srcAddr, .dstAddr, .unitCount, .startReq, .memWait,
    .rdata, .addr, .wdata, .size, .wen, .busActive, .irq, .disableDma
  );

  dmaChecker chk (
    .clk, .rst_b, .startReq, .addr, .wdata, .size, .wen, .busActive, .memWait,
    .irq, .disableDma
  );

  assign rdata = wen ? 32'h0 : (addr ^ 32'hA5A5_0000);  // memory model

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // about one cycle in four stalls
  always @(posedge clk or negedge rst_b) begin
    if (!rst_b) memWait <= 1'b0;
    else memWait <= (($random(seed) & 3) == 0);
  end

  task automatic readTrace();
    int          fd;
    int          n;
    string       line;
    int          ch;
    logic [15:0] c;
    logic [31:0] s;
    logic [31:0] d;
    logic [13:0] cnt;
    logic [3:0]  m;
    fd = $fopen("test/dmaTrace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file test/dmaTrace.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%d %h %h %h %h %b", ch, c, s, d, cnt, m);
          if (n == 6 && nLines < MAX_LINES) begin  // comment lines fail the scan
            lineChan[nLines]  = ch;
            lineCtrl[nLines]  = c;
            lineSrc[nLines]   = s;
            lineDst[nLines]   = d;
            lineCount[nLines] = cnt;
            lineMask[nLines]  = m;
            nLines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic waitFirstUnit(int ch);
    @(negedge clk);
    while (chk.unitsDone(ch) == 0) @(negedge clk);
  endtask

  task automatic runLine(int t);
    int         ch;
    logic [3:0] offWait;
    ch = lineChan[t];
    @(posedge clk);
    ctrl[ch]      <= lineCtrl[t];
    srcAddr[ch]   <= lineSrc[t];
    dstAddr[ch]   <= lineDst[t];
    unitCount[ch] <= lineCount[t];
    chk.arm(ch, lineCtrl[t], lineSrc[t], lineDst[t], lineCount[t]);
    armed[ch] = 1'b1;
    if (lineMask[t] != 4'b0) begin
      @(posedge clk);  // channel loads its registers here
      for (int i = 3; i >= 0; i--) begin
        if (lineMask[t][i]) begin
          @(posedge clk);
          startReq[i] <= 1'b1;
          waitFirstUnit(i);
        end
      end
      // drop start on the edge of the final unit so a repeat channel stays idle
      @(negedge clk);
      while (!(chk.unitsLeft() == 1 && wen && !memWait)) @(negedge clk);
      @(posedge clk);
      startReq <= 4'b0;
      offWait = 4'b0;
      for (int i = 0; i < 4; i++) begin
        // a channel that finished earlier has already pulsed
        if (armed[i] && !ctrl[i][9] && chk.offSeen[i] == 0) offWait[i] = 1'b1;
      end
      while (offWait != 4'b0) begin
        @(negedge clk);
        offWait = offWait & ~disableDma;
      end
      @(posedge clk);
      for (int i = 0; i < 4; i++) begin
        if (armed[i]) ctrl[i][15] <= 1'b0;
      end
      armed = 4'b0;
    end
  endtask

  // watchdog, sized from the trace length
  initial begin
    wait (nLines > 0);
    repeat (200 * nLines + 100) @(posedge clk);
    $display("watchdog expired before the trace completed");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    seed     = 32'h1119563b;
    rst_b    = 1'b0;
    startReq = 4'b0;
    armed    = 4'b0;
    for (int i = 0; i < 4; i++) begin
      ctrl[i]      = 16'h0;
      srcAddr[i]   = 32'h0;
      dstAddr[i]   = 32'h0;
      unitCount[i] = 14'h0;
    end
    readTrace();
    repeat (5) @(posedge clk);
    rst_b <= 1'b1;
    for (int t = 0; t < nLines; t++) begin
      runLine(t);
    end
    repeat (2) @(posedge clk);
    chk.finalCheck();
    $display("lines %0d, checks %0d, errors %0d", nLines, chk.checks, chk.errors);
    if (chk.errors == 0 && nLines > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/dmaTrace.txt ====
# columns: channel ctrl(hex) src(hex) dst(hex) count(hex) startMask(bin)
# a zero start mask only arms the channel, the next started line runs it
# word copy, both addresses increment, irq on
1 C400 02000100 03000000 8 0010
# halfword, source decrements, destination fixed at an upper-lane address
3 80C0 02000210 03000102 6 1000
# halfword, source fixed, destination increments, irq on
0 C100 08000002 06000000 5 0001
# word repeat with destination reload, runs two passes
2 C660 02001000 04000000 4 0100
# priority: channel 0 armed, channel 2 starts first and is preempted
0 C400 02002000 03002000 3 0000
2 8400 02003000 03003000 A 0101

// ==== all.f ====
verilog/dmaCtrlPkg.sv
verilog/dmaBusPkg.sv
verilog/dmaBusIf.sv
verilog/dmaChannelFsm.sv
verilog/dmaAddrPath.sv
verilog/dmaChannel.sv
verilog/dmaArbiter.sv
verilog/dmaController.sv
test/dmaChecker.sv
test/dmaBus_properties.sv
test/dmaTb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module dmaTb -f all.f -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
echo "build or simulation reported a problem, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1
